// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  # design, package first
  - rtl/fetch_pkg.sv
  - rtl/fetch_entry_if.sv
  - rtl/pc_gen.sv
  - rtl/fetch_ctrl.sv
  - rtl/fetch_queue.sv
  - rtl/fetch_top.sv

  # verification
  - target: test
    files:
      - verif/fetch_clock_gen.sv
      - verif/fetch_tb.sv

// ==== rtl/fetch_ctrl.sv ====
// fetch control
// runs the four-phase req/ack cycle toward instruction memory, picks the
// 32-bit half of the returned line and pushes it with its next pc,
// a redirect flushes the queue and turns an open access into a discard

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  // instruction memory
  output logic  imem_req,
  output addr_t imem_addr,
  input  logic  imem_ack,
  input  line_t imem_data,
  // pc generator
  input  addr_t pc,
  output logic  advance,
  // commit stage
  input  logic  redirect_valid,
  // toward the queue
  fetch_entry_if.producer entry
);

  fetch_state_t state, state_next;
  addr_t        addr_q;     // line address of the open access
  logic         can_start;  // room in the queue and no redirect this cycle
  logic         launch;     // open a new access on this edge

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  assign can_start = !entry.full && !redirect_valid;

  // a new req only after ack was seen low, either from idle or at the end
  // of release (back to back accesses)
  assign launch = can_start &&
                  ((state == st_idle) || (state == st_release && !imem_ack));

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (launch) state_next = st_request;
      end
      st_request: begin
        if (imem_ack) state_next = st_release;             // data taken or dropped
        else if (redirect_valid) state_next = st_discard;  // old path, finish quietly
      end
      st_release: begin
        if (!imem_ack) state_next = launch ? st_request : st_idle;
      end
      st_discard: begin
        if (imem_ack) state_next = st_release;  // response ignored
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) state <= st_idle;
    else state <= state_next;
  end

  // line address is held for the whole req phase, pc may move under a redirect
  always_ff @(posedge clock) begin
    if (launch) addr_q <= {pc[ADDR_W-1:3], 3'b000};
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign imem_req  = (state == st_request) || (state == st_discard);
  assign imem_addr = addr_q;

  // pc is untouched since launch unless a redirect came, which blocks the push
  assign entry.push  = (state == st_request) && imem_ack && !redirect_valid;
  assign entry.inst  = pc[2] ? imem_data[63:32] : imem_data[31:0];  // half by pc bit 2
  assign entry.npc   = pc + addr_t'(4);
  assign entry.flush = redirect_valid;
  assign advance     = entry.push;  // pc steps with every pushed word

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // four-phase rule, req is only dropped once the ack was there
  a_req_held: assert property (@(posedge clock) disable iff (reset)
    $fell(imem_req) |-> $past(imem_ack))
    else $error("imem_req dropped before imem_ack");

  // queue never sees a write while it reports full
  a_no_push_full: assert property (@(posedge clock) disable iff (reset)
    entry.push |-> !entry.full)
    else $error("push into a full queue");

  // pc step and queue write are one single-cycle event
  a_adv_push: assert property (@(posedge clock) disable iff (reset)
    (advance || entry.push) |-> (advance && entry.push) ##1 !(advance || entry.push))
    else $error("advance and push out of step");

endmodule

`default_nettype wire

// ==== rtl/fetch_entry_if.sv ====
// fetched entry channel from the fetch control into the instruction queue
// push is a single cycle strobe, full comes back from the queue,
// flush empties the queue on a redirect

`timescale 1ns/1ps
`default_nettype none

interface fetch_entry_if import fetch_pkg::*; ();

  logic  push;   // write one entry this cycle
  inst_t inst;   // selected instruction half
  addr_t npc;    // pc of the instruction plus 4
  logic  full;   // queue has no free slot
  logic  flush;  // drop every queued entry

  // fetch control side
  modport producer (
    output push, inst, npc, flush,
    input  full
  );

  // instruction queue side
  modport consumer (
    input  push, inst, npc, flush,
    output full
  );

endinterface

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
// instruction fetch front end, shared definitions
// widths of addresses, instruction words and memory lines,
// sizing of the instruction queue and the fetch FSM encoding

`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 64;  // pc, next pc and memory address
  localparam int INST_W = 32;  // one instruction word
  localparam int LINE_W = 64;  // one imem line, two instructions

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INST_W-1:0] inst_t;
  typedef logic [LINE_W-1:0] line_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction queue
  ////////////////////////////////////////////////////////////////////////////

  localparam int QUEUE_DEPTH = 4;                     // entries toward dispatch
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);   // index width

  typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;  // read / write pointer
  typedef logic [QUEUE_PTR_W:0]   queue_cnt_t;  // occupancy, 0 up to QUEUE_DEPTH

  ////////////////////////////////////////////////////////////////////////////
  // fetch control FSM
  ////////////////////////////////////////////////////////////////////////////

  // st_idle     no access open, waiting for queue space
  // st_request  req high, waiting for ack
  // st_release  req low, waiting for ack to drop
  // st_discard  req high after a redirect, response gets thrown away
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_request = 2'd1,
    st_release = 2'd2,
    st_discard = 2'd3
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_queue.sv ====
// instruction queue between fetch and dispatch
// circular buffer of QUEUE_DEPTH entries, push from the fetch control,
// pop on a valid/ready transfer, flush drops everything

`timescale 1ns/1ps
`default_nettype none

module fetch_queue import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  fetch_entry_if.consumer entry,
  // dispatch side
  output logic  out_valid,
  input  logic  out_ready,
  output inst_t out_inst,
  output addr_t out_npc
);

  inst_t      inst_mem [QUEUE_DEPTH];  // payload, no reset
  addr_t      npc_mem  [QUEUE_DEPTH];
  queue_ptr_t wr_ptr;
  queue_ptr_t rd_ptr;
  queue_cnt_t count;
  logic       do_push;
  logic       do_pop;

  ////////////////////////////////////////////////////////////////////////////
  // handshake decode
  ////////////////////////////////////////////////////////////////////////////

  assign entry.full = (count == queue_cnt_t'(QUEUE_DEPTH));
  assign out_valid  = (count != '0);

  assign do_push = entry.push && !entry.full;
  assign do_pop  = out_valid && out_ready;

  // head entry, stays put until popped
  assign out_inst = inst_mem[rd_ptr];
  assign out_npc  = npc_mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // a push under flush lands in a slot that is no longer counted
  always_ff @(posedge clock) begin
    if (do_push) begin
      inst_mem[wr_ptr] <= entry.inst;
      npc_mem[wr_ptr]  <= entry.npc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || entry.flush) begin  // flush wins over push and pop
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == queue_ptr_t'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == queue_ptr_t'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or push and pop together
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  a_count_range: assert property (@(posedge clock) disable iff (reset)
    count <= queue_cnt_t'(QUEUE_DEPTH))
    else $error("queue count above depth");

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
// fetch front end top level
// fetch control, program counter and instruction queue tied together,
// memory, commit and dispatch sides brought out as plain ports

`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  // instruction memory, four-phase
  output logic  imem_req,
  output addr_t imem_addr,
  input  logic  imem_ack,
  input  line_t imem_data,
  // commit redirect
  input  logic  redirect_valid,
  input  addr_t redirect_pc,
  // dispatch, valid/ready
  output logic  out_valid,
  input  logic  out_ready,
  output inst_t out_inst,
  output addr_t out_npc
);

  addr_t pc;       // current fetch pc
  logic  advance;  // pc step after a push

  fetch_entry_if entry ();  // control to queue

  ////////////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////////////

  fetch_ctrl i_fetch_ctrl (
    .clock          (clock),
    .reset          (reset),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_ack       (imem_ack),
    .imem_data      (imem_data),
    .pc             (pc),
    .advance        (advance),
    .redirect_valid (redirect_valid),
    .entry          (entry.producer)
  );

  pc_gen i_pc_gen (
    .clock          (clock),
    .reset          (reset),
    .advance        (advance),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pc             (pc)
  );

  fetch_queue i_fetch_queue (
    .clock     (clock),
    .reset     (reset),
    .entry     (entry.consumer),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_inst  (out_inst),
    .out_npc   (out_npc)
  );

endmodule

`default_nettype wire

// ==== rtl/pc_gen.sv ====
// program counter of the fetch stage
// resets to 0, takes the commit redirect target first, otherwise steps
// by 4 when the control reports a pushed word, otherwise holds

`timescale 1ns/1ps
`default_nettype none

module pc_gen import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  advance,         // one word went into the queue
  input  logic  redirect_valid,  // taken branch from commit
  input  addr_t redirect_pc,     // branch target
  output addr_t pc
);

  addr_t pc_q;
  addr_t pc_next;
  addr_t pc_plus_4;

  assign pc_plus_4 = pc_q + addr_t'(4);

  // redirect overrides a stall and a simultaneous advance
  always_comb begin
    if (redirect_valid) begin
      pc_next = redirect_pc;
    end else if (advance) begin
      pc_next = pc_plus_4;
    end else begin
      pc_next = pc_q;  // hold while waiting on memory or queue space
    end
  end

  always_ff @(posedge clock) begin
    if (reset) pc_q <= '0;  // fetch starts at address 0
    else pc_q <= pc_next;
  end

  assign pc = pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // word alignment is kept as long as the redirect targets are aligned
  a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
    (pc_q[1:0] == 2'b00 && !(redirect_valid && redirect_pc[1:0] != 2'b00))
      |=> pc_q[1:0] == 2'b00)
    else $error("pc lost word alignment");

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/fetch_pkg.sv
rtl/fetch_entry_if.sv
rtl/pc_gen.sv
rtl/fetch_ctrl.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verif/fetch_clock_gen.sv
verif/fetch_tb.sv

// ==== verif/fetch_clock_gen.sv ====
// testbench clock and reset source
// 8 ns clock, reset held high for the first 5 rising edges and
// released on a falling edge

`timescale 1ns/1ps
`default_nettype none

module fetch_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // half of the 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);  // release away from the sampling edge
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
// testbench of the fetch front end
// four-phase memory model with random latency, random dispatch ready and
// random redirects, assertions on instruction content, order, hold,
// memory protocol and reset behavior

`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  localparam logic [31:0] LCG_SEED      = 32'hff0b;
  localparam int          N_TRANSFERS   = 2000;   // dispatched words to finish
  localparam int          RESET_TIMEOUT = 20;     // cycles
  localparam int          RUN_TIMEOUT   = 80000;  // cycles
  localparam int          MEM_IDLE  = 0;  // memory model phases
  localparam int          MEM_DELAY = 1;
  localparam int          MEM_HOLD  = 2;
  localparam int          MEM_DROP  = 3;

  logic  clock;
  logic  reset;
  logic  imem_req;
  addr_t imem_addr;
  logic  imem_ack;
  line_t imem_data;
  logic  redirect_valid;
  addr_t redirect_pc;
  logic  out_valid;
  logic  out_ready;
  inst_t out_inst;
  addr_t out_npc;

  logic [31:0]  lcg_state = LCG_SEED;
  int           mem_phase = MEM_IDLE;
  int unsigned  mem_wait;
  int unsigned  cycle_count;
  int unsigned  ready_bias;       // higher value means more back-pressure
  int unsigned  transfer_count = 0;
  int unsigned  redirect_count = 0;
  int unsigned  reset_edges = 0;
  logic         reset_prev = 1'b1;
  addr_t        exp_npc;          // npc of the next word dispatch must see
  string        npc_source;       // why exp_npc has its value
  logic         hold_pending = 1'b0;
  inst_t        held_inst;
  addr_t        held_npc;
  logic         req_prev = 1'b0;
  addr_t        addr_prev;
  fetch_state_t dbg_state;

  fetch_clock_gen i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  fetch_top i_fetch_top (
    .clock          (clock),
    .reset          (reset),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_ack       (imem_ack),
    .imem_data      (imem_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_inst       (out_inst),
    .out_npc        (out_npc)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits of the lcg because the low ones repeat too fast
  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 16) % n;
  endfunction

  // word stored at a byte address is the address inverted
  function automatic inst_t inst_at(input addr_t addr);
    return ~addr[31:0];
  endfunction

  function automatic line_t line_at(input addr_t addr);
    return {inst_at(addr + 64'd4), inst_at(addr)};  // upper half at A+4
  endfunction

  task automatic value_error(input string test, input logic [63:0] expected,
                             input logic [63:0] actual);
    $display("** Error [%s] expected %h, actual %h", test, expected, actual);
    $display("Testbench failed");
    $fatal(1, "check %s did not hold", test);
  endtask

  task automatic plain_failure(input string reason);
    $display("Error: %s", reason);
    $display("Testbench failed");
    $fatal(1, "%s", reason);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (reset) begin
      mem_phase      = MEM_IDLE;
      imem_ack       = 1'b0;
      redirect_valid = 1'b0;
      out_ready      = 1'b0;
      cycle_count    = 0;
      ready_bias     = 0;
    end else begin
      cycle_count++;
      // memory model sees a req raised at the last rising edge
      if (mem_phase == MEM_IDLE && imem_req === 1'b1) begin
        mem_wait  = rand_below(6);
        mem_phase = MEM_DELAY;
      end
      if (mem_phase == MEM_DELAY) begin
        if (mem_wait == 0) begin
          imem_ack  = 1'b1;
          imem_data = line_at(imem_addr);
          mem_phase = MEM_HOLD;
        end else begin
          mem_wait--;
        end
      end else if (mem_phase == MEM_HOLD) begin
        if (imem_req === 1'b0) begin  // ack goes low some cycles after req dropped
          mem_wait  = rand_below(6);
          mem_phase = MEM_DROP;
        end
      end
      if (mem_phase == MEM_DROP) begin
        if (mem_wait == 0) begin
          imem_ack  = 1'b0;
          imem_data = {lcg_next(), lcg_next()};  // junk outside the ack window
          mem_phase = MEM_IDLE;
        end else begin
          mem_wait--;
        end
      end
      // dispatch ready with a bias that changes now and then to fill the queue
      if (cycle_count % 64 == 0) ready_bias = rand_below(16);
      out_ready = (rand_below(16) >= ready_bias);
      // commit redirect to a word aligned target
      redirect_valid = 1'b0;
      if (cycle_count > 64 && rand_below(96) == 0) begin
        redirect_valid = 1'b1;
        redirect_pc    = {lcg_next(), lcg_next()} & ~64'h3;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks on the rising edge against values from before the edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      if (reset_edges > 0) begin  // state is defined after one reset edge
        assert (imem_req === 1'b0) else plain_failure("imem_req high during reset");
        assert (out_valid === 1'b0) else plain_failure("out_valid high during reset");
      end
      reset_edges++;
      exp_npc      = 64'd4;  // first word comes from pc 0
      npc_source   = "reset_first_npc";
      hold_pending = 1'b0;
      req_prev     = 1'b0;
    end else begin
      if (reset_prev) begin
        assert (imem_req === 1'b0) else plain_failure("imem_req high right after reset");
        assert (out_valid === 1'b0) else plain_failure("out_valid high right after reset");
      end
      // memory address rules
      if (imem_req) begin
        assert (imem_addr[2:0] == 3'b000)
          else value_error("imem_addr_align", {imem_addr[63:3], 3'b000}, imem_addr);
        if (req_prev) begin
          assert (imem_addr == addr_prev)
            else value_error("imem_addr_stable", addr_prev, imem_addr);
        end
      end
      // held head under back-pressure
      if (hold_pending) begin
        assert (out_valid) else plain_failure("out_valid dropped without a transfer");
        assert (out_inst == held_inst) else value_error("hold_inst", held_inst, out_inst);
        assert (out_npc == held_npc) else value_error("hold_npc", held_npc, out_npc);
      end
      if (out_valid && out_ready) begin
        assert (out_inst == inst_at(out_npc - 64'd4))
          else value_error("inst_content", inst_at(out_npc - 64'd4), out_inst);
        assert (out_npc == exp_npc) else value_error(npc_source, exp_npc, out_npc);
        exp_npc    = out_npc + 64'd4;
        npc_source = "sequential_npc";
        transfer_count++;
        if (transfer_count % 500 == 0) begin
          dbg_state = i_fetch_top.i_fetch_ctrl.state;
          $display("%0d words dispatched, %0d redirects, fetch state %s",
                   transfer_count, redirect_count, dbg_state.name());
        end
      end
      if (redirect_valid) begin  // overrides the update above
        exp_npc    = redirect_pc + 64'd4;
        npc_source = "redirect_first_npc";
        redirect_count++;
      end
      hold_pending = out_valid && !out_ready && !redirect_valid;
      held_inst    = out_inst;
      held_npc     = out_npc;
      req_prev     = imem_req;
      addr_prev    = imem_addr;
    end
    reset_prev = reset;
  end

  // four-phase ordering against the ack
  req_fall: assert property (@(posedge clock) disable iff (reset)
    $fell(imem_req) |-> $past(imem_ack))
    else plain_failure("imem_req fell before imem_ack was seen high");

  // ack sampled on the edge that raised req
  req_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(imem_req) |-> !$past(imem_ack))
    else plain_failure("imem_req rose while imem_ack was still high");

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned wait_cycles;
    imem_ack       = 1'b0;
    imem_data      = '0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    wait_cycles    = 0;
    while (reset !== 1'b0) begin
      if (wait_cycles >= RESET_TIMEOUT) begin
        plain_failure("reset was never released");
      end else begin
        wait_cycles++;
        @(negedge clock);
      end
    end
    wait_cycles = 0;
    while (transfer_count < N_TRANSFERS) begin
      if (wait_cycles >= RUN_TIMEOUT) begin
        plain_failure("dispatch stalled before all words were transferred");
      end else begin
        wait_cycles++;
        @(negedge clock);
      end
    end
    $display("%0d words dispatched in %0d cycles", transfer_count, wait_cycles);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
